// File: src/decPkg.sv
package decPkg;

	localparam int gprW = 5;	// r0..r31
	localparam int immW = 33;	// 24 jumbo bits over imm9

	// upper three bits of the first halfword select the 32-bit form
	localparam logic [2:0] form32Tag = 3'b111;
	localparam logic [7:0] jumboTag  = 8'hFE;	// bits [15:8] of a prefix

	// alu sub-ops, carried in the low six bits of idUIxt
	localparam logic [5:0] aluSubAdd = 6'd0;
	localparam logic [5:0] aluSubSub = 6'd1;
	localparam logic [5:0] aluSubAnd = 6'd2;
	localparam logic [5:0] aluSubOr  = 6'd3;

	typedef enum logic [5:0] {
		UCMD_NOP   = 6'h00,
		UCMD_MOV   = 6'h01,
		UCMD_ALU   = 6'h02,
		UCMD_ALUI  = 6'h03,
		UCMD_LDI   = 6'h04,
		UCMD_LOAD  = 6'h05,
		UCMD_STORE = 6'h06,
		UCMD_BRA   = 6'h07,
		UCMD_INVOP = 6'h3F	// trap on execute
	} ucmdT;

	typedef enum logic [2:0] {
		IXC_AL = 3'd0,	// always
		IXC_CT = 3'd1,	// if SR.T set
		IXC_CF = 3'd2	// if SR.T clear
	} ixcT;

	typedef enum logic [2:0] {
		IUC_NONE = 3'd0,
		IUC_ALU  = 3'd1,
		IUC_MEM  = 3'd2,
		IUC_BRA  = 3'd3,
		IUC_WX   = 3'd7	// only legal in a wide bundle
	} iucT;

	// 16-bit major opcode, istrWord[15:12]
	typedef enum logic [3:0] {
		OP16_NOP   = 4'd0,
		OP16_MOV   = 4'd1,
		OP16_ADD   = 4'd2,
		OP16_SUB   = 4'd3,
		OP16_AND   = 4'd4,
		OP16_OR    = 4'd5,
		OP16_LDI   = 4'd6,
		OP16_LOAD  = 4'd7,
		OP16_STORE = 4'd8,
		OP16_BRA   = 4'd9
	} op16T;

	// 32-bit major opcode, istrWord[31:28]
	typedef enum logic [3:0] {
		OP32_MOV   = 4'd0,
		OP32_ADD   = 4'd1,
		OP32_SUB   = 4'd2,
		OP32_AND   = 4'd3,
		OP32_OR    = 4'd4,
		OP32_ADDI  = 4'd5,
		OP32_LDI   = 4'd6,
		OP32_LOAD  = 4'd7,
		OP32_STORE = 4'd8,
		OP32_BRA   = 4'd9
	} op32T;

endpackage

// File: src/decOp16.sv
`timescale 1ns/10ps

module decOp16 (
	input  logic [15:0]             istrWord,
	output logic [decPkg::gprW-1:0] regN,
	output logic [decPkg::gprW-1:0] regM,
	output logic [decPkg::gprW-1:0] regO,
	output logic [decPkg::immW-1:0] imm,
	output decPkg::ucmdT            ucmd,
	output decPkg::iucT             iuc,
	output logic [5:0]              subOp
);
	import decPkg::*;

	op16T            opc;
	logic [gprW-1:0] fldN;	// [7:4], zero extended
	logic [gprW-1:0] fldM;	// [3:0]
	logic [gprW-1:0] fldLdi;	// [11:8]
	logic [immW-1:0] imm8;	// sign extended [7:0]
	logic [immW-1:0] disp12;	// sign extended [11:0]

	assign opc    = op16T'(istrWord[15:12]);
	assign fldN   = gprW'(istrWord[7:4]);
	assign fldM   = gprW'(istrWord[3:0]);
	assign fldLdi = gprW'(istrWord[11:8]);
	assign imm8   = {{(immW-8){istrWord[7]}}, istrWord[7:0]};
	assign disp12 = {{(immW-12){istrWord[11]}}, istrWord[11:0]};

	always_comb begin
		// unused fields stay zero
		regN  = '0;
		regM  = '0;
		regO  = '0;
		imm   = '0;
		ucmd  = UCMD_INVOP;
		iuc   = IUC_NONE;
		subOp = '0;

		case (opc)
			OP16_NOP: begin
				ucmd = UCMD_NOP;
			end
			OP16_MOV: begin
				regN = fldN;
				regM = fldM;
				ucmd = UCMD_MOV;
				iuc  = IUC_ALU;
			end
			OP16_ADD, OP16_SUB, OP16_AND, OP16_OR: begin
				regN = fldN;
				regM = fldM;
				regO = fldN;	// two-operand, dest doubles as src
				ucmd = UCMD_ALU;
				iuc  = IUC_ALU;
				case (opc)
					OP16_SUB: subOp = aluSubSub;
					OP16_AND: subOp = aluSubAnd;
					OP16_OR:  subOp = aluSubOr;
					default:  subOp = aluSubAdd;
				endcase
			end
			OP16_LDI: begin
				regN = fldLdi;
				imm  = imm8;
				ucmd = UCMD_LDI;
				iuc  = IUC_ALU;
			end
			OP16_LOAD: begin
				regN = fldN;
				regM = fldM;	// base
				ucmd = UCMD_LOAD;
				iuc  = IUC_MEM;
			end
			OP16_STORE: begin
				regN = fldN;	// data
				regM = fldM;	// base
				ucmd = UCMD_STORE;
				iuc  = IUC_MEM;
			end
			OP16_BRA: begin
				imm  = disp12;
				ucmd = UCMD_BRA;
				iuc  = IUC_BRA;
			end
			default: begin
				ucmd = UCMD_INVOP;	// 10..15 undefined here
			end
		endcase
	end

endmodule

// File: src/decOp32.sv
`timescale 1ns/10ps

module decOp32 (
	input  logic [31:0]             istrWord,
	input  logic                    jumboValid,
	input  logic [23:0]             jumboBits,
	output logic [decPkg::gprW-1:0] regN,
	output logic [decPkg::gprW-1:0] regM,
	output logic [decPkg::gprW-1:0] regO,
	output logic [decPkg::immW-1:0] imm,
	output decPkg::ucmdT            ucmd,
	output decPkg::ixcT             ixc,
	output decPkg::iucT             iuc,
	output logic [5:0]              subOp
);
	import decPkg::*;

	op32T            opc;
	iucT             unitCls;	// class before the WEX override
	logic [gprW-1:0] fldN;
	logic [gprW-1:0] fldM;
	logic [gprW-1:0] fldO;
	logic [8:0]      imm9;
	logic [17:0]     imm18;
	logic [19:0]     disp20;
	logic [immW-1:0] imm9Ext;	// jumbo widened or sign extended
	logic [immW-1:0] imm18Ext;
	logic [immW-1:0] disp20Ext;

	assign opc    = op32T'(istrWord[31:28]);
	assign fldN   = istrWord[4:0];
	assign fldM   = istrWord[27:23];
	assign fldO   = istrWord[22:18];
	assign imm9   = istrWord[22:14];	// overlaps regO
	assign imm18  = istrWord[27:10];
	assign disp20 = istrWord[27:8];

	// pending jumbo supplies the upper 24 bits
	assign imm9Ext   = jumboValid ? {jumboBits, imm9} : {{(immW-9){imm9[8]}}, imm9};
	assign imm18Ext  = {{(immW-18){imm18[17]}}, imm18};	// no jumbo
	assign disp20Ext = {{(immW-20){disp20[19]}}, disp20};	// no jumbo

	// bit 12 set means unconditional, else bit 10 picks the sense
	assign ixc = istrWord[12] ? IXC_AL : (istrWord[10] ? IXC_CF : IXC_CT);
	assign iuc = istrWord[11] ? IUC_WX : unitCls;

	always_comb begin
		regN    = '0;
		regM    = '0;
		regO    = '0;
		imm     = '0;
		ucmd    = UCMD_INVOP;
		unitCls = IUC_NONE;
		subOp   = '0;

		case (opc)
			OP32_MOV: begin
				regN    = fldN;
				regM    = fldM;
				ucmd    = UCMD_MOV;
				unitCls = IUC_ALU;
			end
			OP32_ADD, OP32_SUB, OP32_AND, OP32_OR: begin
				regN    = fldN;
				regM    = fldM;
				regO    = fldO;
				ucmd    = UCMD_ALU;
				unitCls = IUC_ALU;
				case (opc)
					OP32_SUB: subOp = aluSubSub;
					OP32_AND: subOp = aluSubAnd;
					OP32_OR:  subOp = aluSubOr;
					default:  subOp = aluSubAdd;
				endcase
			end
			OP32_ADDI: begin
				regN    = fldN;
				regM    = fldM;
				imm     = imm9Ext;
				ucmd    = UCMD_ALUI;
				unitCls = IUC_ALU;
				subOp   = aluSubAdd;	// only add has an imm form
			end
			OP32_LDI: begin
				regN    = fldN;
				imm     = imm18Ext;
				ucmd    = UCMD_LDI;
				unitCls = IUC_ALU;
			end
			OP32_LOAD, OP32_STORE: begin
				regN    = fldN;
				regM    = fldM;	// base
				imm     = imm9Ext;	// displacement
				ucmd    = (opc == OP32_LOAD) ? UCMD_LOAD : UCMD_STORE;
				unitCls = IUC_MEM;
			end
			OP32_BRA: begin
				imm     = disp20Ext;
				ucmd    = UCMD_BRA;
				unitCls = IUC_BRA;
			end
			default: begin
				ucmd = UCMD_INVOP;	// 10..15 reserved
			end
		endcase
	end

endmodule

// File: src/jumboLatch.sv
`timescale 1ns/10ps

module jumboLatch (
	input  logic        clock,
	input  logic        rstN,
	input  logic        istrValid,
	input  logic [31:0] istrWord,
	output logic        isPrefix,
	output logic        jumboValid,
	output logic [23:0] jumboBits
);
	import decPkg::*;

	// FE tag already implies the 32-bit form bits
	assign isPrefix = (istrWord[15:8] == jumboTag);

	// pending flag, cleared by the consuming instruction
	always_ff @(posedge clock) begin
		if (!rstN) begin
			jumboValid <= 1'b0;
		end else if (istrValid) begin
			jumboValid <= isPrefix;
		end
	end

	// payload only, qualified by jumboValid
	always_ff @(posedge clock) begin
		if (istrValid && isPrefix) begin
			jumboBits <= {istrWord[7:0], istrWord[31:16]};	// later prefix wins
		end
	end

endmodule

// File: src/decOpSel.sv
`timescale 1ns/10ps

module decOpSel (
	input  logic                    clock,
	input  logic                    rstN,
	input  logic                    istrValid,
	input  logic [31:0]             istrWord,
	input  logic                    isPrefix,
	input  logic                    jumboValid,
	input  logic [23:0]             jumboBits,
	input  logic [decPkg::gprW-1:0] regN16,
	input  logic [decPkg::gprW-1:0] regM16,
	input  logic [decPkg::gprW-1:0] regO16,
	input  logic [decPkg::immW-1:0] imm16,
	input  decPkg::ucmdT            ucmd16,
	input  decPkg::iucT             iuc16,
	input  logic [5:0]              subOp16,
	input  logic [decPkg::gprW-1:0] regN32,
	input  logic [decPkg::gprW-1:0] regM32,
	input  logic [decPkg::gprW-1:0] regO32,
	input  logic [decPkg::immW-1:0] imm32,
	input  decPkg::ucmdT            ucmd32,
	input  decPkg::ixcT             ixc32,
	input  decPkg::iucT             iuc32,
	input  logic [5:0]              subOp32,
	output logic                    idValid,
	output logic [decPkg::gprW-1:0] idRegN,
	output logic [decPkg::gprW-1:0] idRegM,
	output logic [decPkg::gprW-1:0] idRegO,
	output logic [decPkg::immW-1:0] idImm,
	output logic [decPkg::immW-1:0] idImmB,
	output logic [8:0]              idUCmd,	// {ixc, ucmd}
	output logic [8:0]              idUIxt	// {iuc, sub-op}
);
	import decPkg::*;

	logic            is32;
	logic            take;	// valid and not a prefix
	logic [gprW-1:0] selRegN;
	logic [gprW-1:0] selRegM;
	logic [gprW-1:0] selRegO;
	logic [immW-1:0] selImm;
	logic [immW-1:0] selImmB;
	ucmdT            selUCmd;
	ixcT             selIxc;
	iucT             selIuc;
	logic [5:0]      selSubOp;

	assign is32 = (istrWord[15:13] == form32Tag);
	assign take = istrValid && !isPrefix;

	// consumed jumbo reported raw, zero extended
	assign selImmB = jumboValid ? immW'(jumboBits) : '0;

	always_comb begin
		if (is32) begin
			selRegN  = regN32;
			selRegM  = regM32;
			selRegO  = regO32;
			selImm   = imm32;
			selUCmd  = ucmd32;
			selIxc   = ixc32;
			selIuc   = iuc32;
			selSubOp = subOp32;
		end else begin
			selRegN  = regN16;
			selRegM  = regM16;
			selRegO  = regO16;
			selImm   = imm16;
			selUCmd  = ucmd16;
			selIxc   = IXC_AL;	// no predication in 16-bit forms
			selIuc   = iuc16;
			selSubOp = subOp16;
		end

		// WEX-only form outside a bundle traps, condition kept
		if (selIuc == IUC_WX)
			selUCmd = UCMD_INVOP;
	end

	always_ff @(posedge clock) begin
		if (!rstN) begin
			idValid <= 1'b0;
			idRegN  <= '0;
			idRegM  <= '0;
			idRegO  <= '0;
			idImm   <= '0;
			idImmB  <= '0;
			idUCmd  <= '0;
			idUIxt  <= '0;
		end else begin
			idValid <= take;
			if (take) begin	// hold while idle or on prefix
				idRegN <= selRegN;
				idRegM <= selRegM;
				idRegO <= selRegO;
				idImm  <= selImm;
				idImmB <= selImmB;
				idUCmd <= {selIxc, selUCmd};
				idUIxt <= {selIuc, selSubOp};
			end
		end
	end

endmodule

// File: src/decOp.sv
`timescale 1ns/10ps

module decOp (
	input  logic                    clock,
	input  logic                    rstN,
	input  logic                    istrValid,
	input  logic [31:0]             istrWord,
	output logic                    idValid,
	output logic [decPkg::gprW-1:0] idRegN,
	output logic [decPkg::gprW-1:0] idRegM,
	output logic [decPkg::gprW-1:0] idRegO,
	output logic [decPkg::immW-1:0] idImm,
	output logic [decPkg::immW-1:0] idImmB,
	output logic [8:0]              idUCmd,
	output logic [8:0]              idUIxt
);
	import decPkg::*;

	logic [gprW-1:0] regN16, regM16, regO16;
	logic [immW-1:0] imm16;
	ucmdT            ucmd16;
	iucT             iuc16;
	logic [5:0]      subOp16;
	logic [gprW-1:0] regN32, regM32, regO32;
	logic [immW-1:0] imm32;
	ucmdT            ucmd32;
	ixcT             ixc32;
	iucT             iuc32;
	logic [5:0]      subOp32;
	logic            isPrefix;
	logic            jumboValid;
	logic [23:0]     jumboBits;

	// 16-bit decoder sees the low halfword only
	decOp16 uDec16 (
		.istrWord(istrWord[15:0]),
		.regN(regN16), .regM(regM16), .regO(regO16),
		.imm(imm16), .ucmd(ucmd16), .iuc(iuc16), .subOp(subOp16)
	);

	decOp32 uDec32 (
		.istrWord(istrWord), .jumboValid(jumboValid), .jumboBits(jumboBits),
		.regN(regN32), .regM(regM32), .regO(regO32),
		.imm(imm32), .ucmd(ucmd32), .ixc(ixc32), .iuc(iuc32), .subOp(subOp32)
	);

	jumboLatch uJumbo (
		.clock(clock), .rstN(rstN), .istrValid(istrValid), .istrWord(istrWord),
		.isPrefix(isPrefix), .jumboValid(jumboValid), .jumboBits(jumboBits)
	);

	decOpSel uSel (
		.clock(clock), .rstN(rstN), .istrValid(istrValid), .istrWord(istrWord),
		.isPrefix(isPrefix), .jumboValid(jumboValid), .jumboBits(jumboBits),
		.regN16(regN16), .regM16(regM16), .regO16(regO16), .imm16(imm16),
		.ucmd16(ucmd16), .iuc16(iuc16), .subOp16(subOp16),
		.regN32(regN32), .regM32(regM32), .regO32(regO32), .imm32(imm32),
		.ucmd32(ucmd32), .ixc32(ixc32), .iuc32(iuc32), .subOp32(subOp32),
		.idValid(idValid), .idRegN(idRegN), .idRegM(idRegM), .idRegO(idRegO),
		.idImm(idImm), .idImmB(idImmB), .idUCmd(idUCmd), .idUIxt(idUIxt)
	);

endmodule

// File: sim/decOp_checker.sv
`timescale 1ns/10ps

module decOp_checker (
	input logic        clock,
	input logic        rstN,
	input logic        istrValid,
	input logic [31:0] istrWord,
	input logic        idValid
);
	import decPkg::*;

	logic isPrefix;

	assign isPrefix = (istrWord[15:8] == jumboTag);	// same tag test as the latch

	// decoded word shows up one edge later
	validAfterWord: assert property (@(posedge clock) disable iff (!rstN)
		(istrValid && !isPrefix) |=> idValid)
		else $error("idValid missing one cycle after a valid instruction");

	// prefixes and idle cycles leave no pulse
	quietAfterPrefixOrIdle: assert property (@(posedge clock) disable iff (!rstN)
		(!istrValid || isPrefix) |=> !idValid)
		else $error("idValid raised after a prefix or an idle cycle");

	lowInReset: assert property (@(posedge clock)
		!rstN |=> !idValid)
		else $error("idValid high while reset was asserted");

endmodule

bind decOp decOp_checker uChecker (
	.clock(clock),
	.rstN(rstN),
	.istrValid(istrValid),
	.istrWord(istrWord),
	.idValid(idValid)
);

// File: sim/decOp_tb.sv
`timescale 1ns/10ps

module decOp_tb;
	import decPkg::*;

	localparam int clkPeriod      = 20;
	localparam int driveDelay     = 2;	// after the rising edge
	localparam int resetCycles    = 16;
	localparam int testCycles     = 3000;
	localparam int watchdogCycles = resetCycles + testCycles + 100;
	localparam logic [31:0] seed  = 32'd10189;

	logic            clock;
	logic            rstN;
	logic            istrValid;
	logic [31:0]     istrWord;
	logic            idValid;
	logic [gprW-1:0] idRegN;
	logic [gprW-1:0] idRegM;
	logic [gprW-1:0] idRegO;
	logic [immW-1:0] idImm;
	logic [immW-1:0] idImmB;
	logic [8:0]      idUCmd;
	logic [8:0]      idUIxt;

	logic [31:0]     rngState;
	logic            pend;	// model copy of the pending jumbo
	logic [23:0]     jb;
	logic            wantImm9;	// steer toward an imm9 form after a prefix
	logic [99:0]     expQ[$];	// {valid, regN, regM, regO, imm, immB, ucmd, uixt}
	int              jumboHits;

	decOp uut (
		.clock(clock), .rstN(rstN), .istrValid(istrValid), .istrWord(istrWord),
		.idValid(idValid), .idRegN(idRegN), .idRegM(idRegM), .idRegO(idRegO),
		.idImm(idImm), .idImmB(idImmB), .idUCmd(idUCmd), .idUIxt(idUIxt)
	);

	initial begin
		clock = 1'b0;
		forever #(clkPeriod / 2) clock = ~clock;
	end

	initial begin
		#(watchdogCycles * clkPeriod);
		$display("timeout: run did not finish within %0d cycles", watchdogCycles);
		$display("SOME TESTS FAILED");
		$fatal(1, "watchdog expired");
	end

	function automatic logic [31:0] xorshift32(input logic [31:0] s);
		logic [31:0] x;
		x = s;
		x = x ^ (x << 13);
		x = x ^ (x >> 17);
		x = x ^ (x << 5);
		return x;
	endfunction

	// random word from one of the stimulus classes
	task automatic pickWord(output logic v, output logic [31:0] w);
		logic [31:0] r;
		logic [3:0]  kind;
		rngState = xorshift32(rngState);
		r = rngState;
		rngState = xorshift32(rngState);
		w = rngState;	// noise in every unused bit
		v = 1'b1;
		kind = r[3:0];
		if (wantImm9 && r[8])
			kind = 4'd15;
		case (kind)
			4'd0, 4'd1: v = 1'b0;	// idle
			4'd2, 4'd3, 4'd4, 4'd5: w[15:12] = r[7:4] % 14;	// 16-bit opcodes 0..13
			4'd6, 4'd7, 4'd8, 4'd9: begin
				w[15:13] = 3'b111;
				w[11]    = 1'b0;
				w[31:28] = r[7:4] % 10;
			end
			4'd10, 4'd11: w[15:13] = 3'b111;	// wex below
			4'd12, 4'd13: w[15:8] = jumboTag;
			4'd14: begin
				w[15:13] = 3'b111;
				w[11]    = 1'b0;
				w[31:28] = 4'd10 + (r[7:4] % 6);	// undefined
			end
			default: begin
				w[15:13] = 3'b111;
				w[11]    = 1'b0;
				w[31:28] = (r[5:4] == 2'd1) ? 4'd7 : ((r[5:4] == 2'd2) ? 4'd8 : 4'd5);
			end
		endcase
		if (kind == 4'd10 || kind == 4'd11)
			w[11] = 1'b1;
		if (v)
			wantImm9 = (w[15:8] == jumboTag);
	endtask

	// reference decode from the encoding tables
	task automatic predict(input logic [31:0] w, input logic pnd, input logic [23:0] jbits,
			output logic [gprW-1:0] rn, output logic [gprW-1:0] rm,
			output logic [gprW-1:0] ro, output logic [immW-1:0] im,
			output logic [immW-1:0] imb, output logic [8:0] uc, output logic [8:0] ux);
		logic [3:0]      op;
		logic [5:0]      cmd;
		logic [2:0]      cond;
		logic [2:0]      unit;
		logic [5:0]      sub;
		logic [immW-1:0] wide9;
		rn   = '0;
		rm   = '0;
		ro   = '0;
		im   = '0;
		imb  = pnd ? {9'd0, jbits} : '0;	// any consumer reports the jumbo
		cmd  = UCMD_INVOP;
		cond = IXC_AL;
		unit = IUC_NONE;
		sub  = '0;
		if (w[15:13] != 3'b111) begin
			op = w[15:12];
			if (op == 4'd1 || op == 4'd7 || op == 4'd8 || (op >= 4'd2 && op <= 4'd5)) begin
				rn = {1'b0, w[7:4]};
				rm = {1'b0, w[3:0]};
			end
			case (op)
				4'd0: cmd = UCMD_NOP;
				4'd1: begin
					cmd  = UCMD_MOV;
					unit = IUC_ALU;
				end
				4'd2, 4'd3, 4'd4, 4'd5: begin
					cmd  = UCMD_ALU;
					unit = IUC_ALU;
					sub  = {2'b00, op - 4'd2};
					ro   = rn;
				end
				4'd6: begin
					cmd  = UCMD_LDI;
					unit = IUC_ALU;
					rn   = {1'b0, w[11:8]};
					im   = {{25{w[7]}}, w[7:0]};
				end
				4'd7, 4'd8: begin
					cmd  = (op == 4'd7) ? UCMD_LOAD : UCMD_STORE;
					unit = IUC_MEM;
				end
				4'd9: begin
					cmd  = UCMD_BRA;
					unit = IUC_BRA;
					im   = {{21{w[11]}}, w[11:0]};
				end
				default: cmd = UCMD_INVOP;
			endcase
		end else begin
			op    = w[31:28];
			cond  = w[12] ? IXC_AL : (w[10] ? IXC_CF : IXC_CT);
			wide9 = pnd ? {jbits, w[22:14]} : {{24{w[22]}}, w[22:14]};
			if (op <= 4'd6 || op == 4'd7 || op == 4'd8)
				rn = w[4:0];
			if (op <= 4'd5 || op == 4'd7 || op == 4'd8)
				rm = w[27:23];
			case (op)
				4'd0: begin
					cmd  = UCMD_MOV;
					unit = IUC_ALU;
				end
				4'd1, 4'd2, 4'd3, 4'd4: begin
					cmd  = UCMD_ALU;
					unit = IUC_ALU;
					sub  = {2'b00, op - 4'd1};
					ro   = w[22:18];
				end
				4'd5: begin
					cmd  = UCMD_ALUI;
					unit = IUC_ALU;
					im   = wide9;
				end
				4'd6: begin
					cmd  = UCMD_LDI;
					unit = IUC_ALU;
					im   = {{15{w[27]}}, w[27:10]};
				end
				4'd7, 4'd8: begin
					cmd  = (op == 4'd7) ? UCMD_LOAD : UCMD_STORE;
					unit = IUC_MEM;
					im   = wide9;
				end
				4'd9: begin
					cmd  = UCMD_BRA;
					unit = IUC_BRA;
					im   = {{13{w[27]}}, w[27:8]};
				end
				default: cmd = UCMD_INVOP;
			endcase
			if (w[11]) begin	// wex form traps and keeps its condition
				unit = IUC_WX;
				cmd  = UCMD_INVOP;
			end
		end
		uc = {cond, cmd};
		ux = {unit, sub};
	endtask

	task automatic checkField(input string name, input logic [immW-1:0] act,
			input logic [immW-1:0] exp);
		assert (act === exp) else begin
			$display("Fail %s: expected 0x%0h, actual 0x%0h", name, exp, act);
			$display("SOME TESTS FAILED");
			$fatal(1, "output mismatch");
		end
	endtask

	task automatic checkOutputs;
		logic            eV;
		logic [gprW-1:0] eRn, eRm, eRo;
		logic [immW-1:0] eIm, eImb;
		logic [8:0]      eUc, eUx;
		assert (expQ.size() > 0) else begin
			$display("no expected result was queued for this cycle");
			$display("SOME TESTS FAILED");
			$fatal(1, "model queue empty");
		end
		{eV, eRn, eRm, eRo, eIm, eImb, eUc, eUx} = expQ.pop_front();
		checkField("idValid", idValid, eV);
		checkField("idRegN", idRegN, eRn);
		checkField("idRegM", idRegM, eRm);
		checkField("idRegO", idRegO, eRo);
		checkField("idImm", idImm, eIm);
		checkField("idImmB", idImmB, eImb);
		checkField("idUCmd", idUCmd, eUc);
		checkField("idUIxt", idUIxt, eUx);
	endtask

	initial begin : stimulus
		logic            v;
		logic            take;
		logic [31:0]     w;
		logic [gprW-1:0] pRn, pRm, pRo;
		logic [immW-1:0] pIm, pImb;
		logic [8:0]      pUc, pUx;
		logic [99:0]     held;	// last decoded result, outputs hold it
		rstN        = 1'b0;
		istrValid   = 1'b0;
		istrWord    = '0;
		rngState    = seed;
		pend        = 1'b0;
		jb          = '0;
		wantImm9    = 1'b0;
		held        = '0;
		jumboHits   = 0;
		expQ.push_back('0);	// first edge lands in reset
		for (int cyc = 1; cyc <= resetCycles + testCycles; cyc++) begin
			@(posedge clock);
			#driveDelay;
			checkOutputs();
			pickWord(v, w);
			if (cyc < resetCycles) begin	// garbage while held in reset
				rstN = 1'b0;
				pend = 1'b0;
				held = '0;
				expQ.push_back('0);
			end else begin
				rstN = 1'b1;
				take = v && (w[15:8] != jumboTag);
				if (take) begin
					predict(w, pend, jb, pRn, pRm, pRo, pIm, pImb, pUc, pUx);
					held = {1'b1, pRn, pRm, pRo, pIm, pImb, pUc, pUx};
					if (pend && w[15:13] == 3'b111 && !w[11]
							&& (w[31:28] == 4'd5 || w[31:28] == 4'd7 || w[31:28] == 4'd8))
						jumboHits++;
				end
				held[99] = take;
				expQ.push_back(held);
				if (v) begin
					pend = (w[15:8] == jumboTag);	// any valid word clears or reloads
					if (pend)
						jb = {w[7:0], w[31:16]};
				end
			end
			istrValid = v;
			istrWord  = w;
		end
		@(posedge clock);
		#driveDelay;
		checkOutputs();
		if (jumboHits > 0) begin
			$display("ALL TESTS PASSED");
			$finish;
		end else begin
			$display("no prefix was followed by an imm9 form");
			$display("SOME TESTS FAILED");
			$fatal(1, "stimulus did not cover the jumbo path");
		end
	end

endmodule

// File: decOp.f
src/decPkg.sv
src/decOp16.sv
src/decOp32.sv
src/jumboLatch.sv
src/decOpSel.sv
src/decOp.sv
sim/decOp_checker.sv
sim/decOp_tb.sv

// File: Bender.yml
package:
  name: decOp

sources:
  - src/decPkg.sv
  - src/decOp16.sv
  - src/decOp32.sv
  - src/jumboLatch.sv
  - src/decOpSel.sv
  - src/decOp.sv
  - target: simulation
    files:
      - sim/decOp_checker.sv
      - sim/decOp_tb.sv
